// File: verification/cart_golden.txt
// columns: op_f1_f2_f3_f4_f5. op 5 starts test f1, op 0 ends the run.
// op 1 apb write (f1 offset, f2 data), op 2 apb read (f2 expected prdata), f5 = pslverr.
// op 3 cpu write (f1 addr, f2 data). op 4 probe (f1 cpu addr, f2 ppu addr, f3 prg, f4 chr, f5 a10).
5_0001_00000000_00000_00000_0 // nom after reset.
4_8000_00000000_00000_00000_0
4_C000_00002800_00000_00800_1
1_0004_00000001_00000_00000_0
4_C123_00002400_00123_00400_1
4_8000_00002800_00000_00800_0
5_0002_00000000_00000_00000_0 // apb register access.
1_0000_00000063_00000_00000_0
2_0000_00000063_00000_00000_0
1_0004_FFFFFFFF_00000_00000_0
2_0004_00001F01_00000_00000_0
1_0004_00000001_00000_00000_0
1_0008_00000002_00000_00000_1
2_0008_00000000_00000_00000_1
2_0004_00000001_00000_00000_0
4_C123_00002400_00123_00400_1
5_0003_00000000_00000_00000_0 // mapper 2, mask 7.
1_0000_00000002_00000_00000_0
1_0004_00000700_00000_00000_0
3_8000_00000005_00000_00000_0
3_C000_0000000E_00000_00000_0
4_BFFF_00001FFF_1BFFF_01FFF_1
3_8000_00000003_00000_00000_0
3_6000_00000001_00000_00000_0
4_8123_00000000_0C123_00000_0
4_C000_00000C00_1C000_00C00_1
5_0004_00000000_00000_00000_0 // mapper 66.
1_0000_00000042_00000_00000_0
1_0004_00000701_00000_00000_0
3_8000_00000031_00000_00000_0
4_8123_00000456_18123_02456_1
4_FFFF_00002800_1FFFF_02800_0
5_0005_00000000_00000_00000_0 // mapper 1, serial loads.
1_0000_00000001_00000_00000_0
3_8000_00000080_00000_00000_0
3_8000_00000001_00000_00000_0
3_8000_00000001_00000_00000_0
3_8000_00000080_00000_00000_0 // restart mid sequence.
3_8000_00000001_00000_00000_0
3_8000_00000001_00000_00000_0
3_8000_00000001_00000_00000_0
3_8000_00000001_00000_00000_0
3_8000_00000000_00000_00000_0 // control 0x0f.
3_E000_00000001_00000_00000_0
3_E000_00000000_00000_00000_0
3_E000_00000001_00000_00000_0
3_E000_00000000_00000_00000_0
3_E000_00000001_00000_00000_0 // prg 0x15, bit 4 dropped.
4_8123_00002800_14123_00800_1
4_C000_00000000_1C000_00000_0
3_C000_00000001_00000_00000_0
3_C000_00000001_00000_00000_0
3_C000_00000001_00000_00000_0
3_C000_00000000_00000_00000_0
3_C000_00000000_00000_00000_0 // chr1 0x07.
3_9FFF_00000000_00000_00000_0
3_9FFF_00000001_00000_00000_0
3_9FFF_00000000_00000_00000_0
3_9FFF_00000001_00000_00000_0
3_9FFF_00000003_00000_00000_0 // control 0x1a, low nibble 3 also seen by mapper 2.
4_8123_00001234_00123_07234_0
4_D000_00000634_15000_00634_1
5_0006_00000000_00000_00000_0 // back to mapper 2, then unknown 99.
1_0000_00000002_00000_00000_0
4_8123_00000C00_0C123_00C00_1
1_0000_00000063_00000_00000_0
4_C123_00000800_04123_00800_0
0_0000_00000000_00000_00000_0

// File: files.f
rtl/cfg_pkg.sv
rtl/map_pkg.sv
rtl/cfg_regs.sv
rtl/map_nom.sv
rtl/map_002.sv
rtl/map_066.sv
rtl/map_001.sv
rtl/map_hub.sv
rtl/cart_top.sv
verification/tb_cart.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ns --top-module tb_cart -f files.f -o tb_cart \
	> build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_cart > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

// File: verification/tb_cart.sv
`default_nettype none

module tb_cart;
	timeunit 1ns;
	timeprecision 1ns;

	import cfg_pkg::*;
	import map_pkg::*;

	localparam int DEPTH = 128;

	logic     clk;
	logic     rst;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	cpu_bus_t bus;
	map_out_t map_out;

	// op, f1, f2, f3, f4, f5 as laid out in the golden file.
	logic [95:0] vec [0:DEPTH-1];
	logic [15:0] cur_test = 16'd0;
	int n_vec = 0;
	int limit = 0;
	int cycles = 0;
	int errs = 0;
	int test_errs = 0;
	int n_pass = 0;
	int n_fail = 0;

	cart_top dut0 (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.bus     (bus),
		.map_out (map_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("timeout: vectors still running after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
			errs++;
			test_errs++;
		end
	endtask

	// setup, access, then idle. checked mid access cycle.
	task automatic apb_access(input logic wr, input logic [3:0] off, input logic [31:0] data,
			input logic exp_err);
		next_cycle();
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = off;
		apb_req.pwdata  = wr ? data : 32'd0;
		next_cycle();
		apb_req.penable = 1'b1;
		@(negedge clk);
		compare("pready", 32'd1, {31'd0, apb_rsp.pready});
		compare("pslverr", {31'd0, exp_err}, {31'd0, apb_rsp.pslverr});
		if (!wr) begin
			compare("prdata", data, apb_rsp.prdata);
		end
		next_cycle();
		apb_req = '0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		next_cycle();
		bus.cpu_addr = addr;
		bus.cpu_data = data;
		bus.cpu_we   = 1'b1;
		next_cycle();  // strobe taken at this edge.
		bus.cpu_we = 1'b0;
	endtask

	task automatic probe(input logic [15:0] ca, input logic [13:0] pa, input logic [18:0] prg,
			input logic [16:0] chr, input logic a10);
		next_cycle();
		bus.cpu_addr = ca;
		bus.ppu_addr = pa;
		next_cycle();
		compare("prg_addr", {13'd0, prg}, {13'd0, map_out.prg_addr});
		compare("chr_addr", {15'd0, chr}, {15'd0, map_out.chr_addr});
		compare("ciram_a10", {31'd0, a10}, {31'd0, map_out.ciram_a10});
		compare("chr_ce", {31'd0, pa < 14'h2000}, {31'd0, map_out.chr_ce});
	endtask

	task automatic close_test();
		if (cur_test != 16'd0) begin
			if (test_errs == 0) begin
				$display("test %0d done, no mismatches", cur_test);
				n_pass++;
			end else begin
				$display("test %0d done, %0d mismatches", cur_test, test_errs);
				n_fail++;
			end
		end
		test_errs = 0;
	endtask

	initial begin
		logic [95:0] v;
		int i;
		rst     = 1'b1;
		apb_req = '0;
		bus     = '0;
		$readmemh("verification/cart_golden.txt", vec);
		while (n_vec < DEPTH && vec[7'(n_vec)][95:92] != 4'h0) begin
			n_vec++;
		end
		limit = n_vec * 4 + 100;
		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;
		for (i = 0; i < n_vec; i++) begin
			v = vec[7'(i)];
			case (v[95:92])
				4'h1: apb_access(1'b1, v[79:76], v[75:44], v[0]);
				4'h2: apb_access(1'b0, v[79:76], v[75:44], v[0]);
				4'h3: cpu_write(v[91:76], v[51:44]);
				4'h4: probe(v[91:76], v[57:44], v[42:24], v[20:4], v[0]);
				4'h5: begin
					close_test();
					cur_test = v[91:76];
				end
				default: begin
					$display("unknown operation code %h on vector %0d", v[95:92], i);
					errs++;
				end
			endcase
		end
		close_test();
		$display("tests passed %0d failed %0d", n_pass, n_fail);
		if (errs == 0 && n_fail == 0 && n_vec > 0) begin
			$display("TB PASSED");
		end else begin
			if (n_vec == 0) begin
				$display("no vectors were read from the golden file");
			end
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/cart_top.sv
`default_nettype none

module cart_top (
	input  logic              clk,
	input  logic              rst,
	input  cfg_pkg::apb_req_t apb_req,
	output cfg_pkg::apb_rsp_t apb_rsp,
	input  map_pkg::cpu_bus_t bus,
	output map_pkg::map_out_t map_out
);
	import cfg_pkg::*;

	sys_cfg_t sys_cfg;

	cfg_regs cfg0 (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.sys_cfg (sys_cfg)
	);

	map_hub hub0 (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus),
		.sys_cfg (sys_cfg),
		.map_out (map_out)
	);

endmodule

`default_nettype wire

// File: rtl/map_hub.sv
`default_nettype none

module map_hub (
	input  logic              clk,
	input  logic              rst,
	input  map_pkg::cpu_bus_t bus,
	input  cfg_pkg::sys_cfg_t sys_cfg,
	output map_pkg::map_out_t map_out
);
	import map_pkg::*;

	map_out_t out_nom;
	map_out_t out_001;
	map_out_t out_002;
	map_out_t out_066;

	// every mapper sees every bus cycle.
	map_nom mnom (.clk(clk), .rst(rst), .bus(bus), .sys_cfg(sys_cfg), .map_out(out_nom));
	map_001 m001 (.clk(clk), .rst(rst), .bus(bus), .sys_cfg(sys_cfg), .map_out(out_001));
	map_002 m002 (.clk(clk), .rst(rst), .bus(bus), .sys_cfg(sys_cfg), .map_out(out_002));
	map_066 m066 (.clk(clk), .rst(rst), .bus(bus), .sys_cfg(sys_cfg), .map_out(out_066));

	always_comb begin
		case (sys_cfg.map_idx)
			MAP_NOM: map_out = out_nom;
			MAP_001: map_out = out_001;
			MAP_002: map_out = out_002;
			MAP_066: map_out = out_066;
			default: map_out = out_nom;  // unknown mapper.
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/map_001.sv
`default_nettype none

module map_001 (
	input  logic              clk,
	input  logic              rst,
	input  map_pkg::cpu_bus_t bus,
	input  cfg_pkg::sys_cfg_t sys_cfg,
	output map_pkg::map_out_t map_out
);
	import map_pkg::*;

	logic [4:0] sr_q;
	logic [2:0] cnt_q;
	logic [4:0] sr_next;
	logic [4:0] ctrl_q;
	logic [4:0] chr0_q;
	logic [4:0] chr1_q;
	logic [3:0] prg_q;
	logic [4:0] prg_bank;
	logic [4:0] chr_bank;

	assign sr_next = {bus.cpu_data[0], sr_q[4:1]};  // lsb first.

	always_ff @(posedge clk) begin
		if (rst) begin
			sr_q   <= '0;
			cnt_q  <= '0;
			ctrl_q <= 5'h0c;
			chr0_q <= '0;
			chr1_q <= '0;
			prg_q  <= '0;
		end else if (rom_wr(bus)) begin
			if (bus.cpu_data[7]) begin
				sr_q   <= '0;
				cnt_q  <= '0;
				ctrl_q <= ctrl_q | 5'h0c;
			end else if (cnt_q == 3'd4) begin
				// fifth write commits, a14:a13 picks the target.
				case (bus.cpu_addr[14:13])
					2'd0: ctrl_q <= sr_next;
					2'd1: chr0_q <= sr_next;
					2'd2: chr1_q <= sr_next;
					default: prg_q <= sr_next[3:0];  // bit 4 is wram enable.
				endcase
				sr_q  <= '0;
				cnt_q <= '0;
			end else begin
				sr_q  <= sr_next;
				cnt_q <= cnt_q + 3'd1;
			end
		end
	end

	always_comb begin
		case (ctrl_q[3:2])
			2'd0, 2'd1: prg_bank = {1'b0, prg_q[3:1], bus.cpu_addr[14]};
			2'd2: prg_bank = bus.cpu_addr[14] ? {1'b0, prg_q} : 5'd0;
			default: prg_bank = bus.cpu_addr[14] ? sys_cfg.prg_mask : {1'b0, prg_q};
		endcase

		// 4 KB units.
		if (ctrl_q[4]) begin
			chr_bank = bus.ppu_addr[12] ? chr1_q : chr0_q;
		end else begin
			chr_bank = {chr0_q[4:1], bus.ppu_addr[12]};
		end

		map_out.prg_addr = {prg_bank & sys_cfg.prg_mask, bus.cpu_addr[13:0]};
		map_out.chr_addr = {chr_bank, bus.ppu_addr[11:0]};
		map_out.chr_ce   = chr_sel(bus.ppu_addr);

		case (ctrl_q[1:0])
			2'd0: map_out.ciram_a10 = 1'b0;  // one screen low.
			2'd1: map_out.ciram_a10 = 1'b1;
			2'd2: map_out.ciram_a10 = bus.ppu_addr[10];
			default: map_out.ciram_a10 = bus.ppu_addr[11];
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/map_066.sv
`default_nettype none

module map_066 (
	input  logic              clk,
	input  logic              rst,
	input  map_pkg::cpu_bus_t bus,
	input  cfg_pkg::sys_cfg_t sys_cfg,
	output map_pkg::map_out_t map_out
);
	import map_pkg::*;

	logic [1:0] prg_q;  // 32 KB bank.
	logic [1:0] chr_q;  // 8 KB bank.

	// one register carries both banks.
	always_ff @(posedge clk) begin
		if (rst) begin
			prg_q <= '0;
			chr_q <= '0;
		end else if (rom_wr(bus)) begin
			prg_q <= bus.cpu_data[5:4];
			chr_q <= bus.cpu_data[1:0];
		end
	end

	always_comb begin
		map_out.prg_addr  = {2'd0, prg_q, bus.cpu_addr[14:0]};
		map_out.chr_addr  = {2'd0, chr_q, bus.ppu_addr[12:0]};
		map_out.ciram_a10 = nt_a10(bus.ppu_addr, sys_cfg.mirror_v);
		map_out.chr_ce    = chr_sel(bus.ppu_addr);
	end

endmodule

`default_nettype wire

// File: rtl/map_002.sv
`default_nettype none

module map_002 (
	input  logic              clk,
	input  logic              rst,
	input  map_pkg::cpu_bus_t bus,
	input  cfg_pkg::sys_cfg_t sys_cfg,
	output map_pkg::map_out_t map_out
);
	import map_pkg::*;

	logic [3:0] bank_q;
	logic [4:0] prg_bank;

	always_ff @(posedge clk) begin
		if (rst) begin
			bank_q <= '0;
		end else if (rom_wr(bus)) begin
			bank_q <= bus.cpu_data[3:0];
		end
	end

	// upper window pinned to the last bank.
	assign prg_bank = bus.cpu_addr[14] ? sys_cfg.prg_mask :
	                  ({1'b0, bank_q} & sys_cfg.prg_mask);

	always_comb begin
		map_out.prg_addr  = {prg_bank, bus.cpu_addr[13:0]};
		map_out.chr_addr  = {4'd0, bus.ppu_addr[12:0]};  // chr ram, unbanked.
		map_out.ciram_a10 = nt_a10(bus.ppu_addr, sys_cfg.mirror_v);
		map_out.chr_ce    = chr_sel(bus.ppu_addr);
	end

endmodule

`default_nettype wire

// File: rtl/map_nom.sv
`default_nettype none

module map_nom (
	input  logic              clk,
	input  logic              rst,
	input  map_pkg::cpu_bus_t bus,
	input  cfg_pkg::sys_cfg_t sys_cfg,
	output map_pkg::map_out_t map_out
);
	import map_pkg::*;

	logic [4:0] prg_bank;

	// 16 KB carts mirror the upper half onto the lower.
	assign prg_bank = {4'd0, bus.cpu_addr[14]} & sys_cfg.prg_mask;

	always_comb begin
		map_out.prg_addr  = {prg_bank, bus.cpu_addr[13:0]};
		map_out.chr_addr  = {4'd0, bus.ppu_addr[12:0]};
		map_out.ciram_a10 = nt_a10(bus.ppu_addr, sys_cfg.mirror_v);
		map_out.chr_ce    = chr_sel(bus.ppu_addr);
	end

endmodule

`default_nettype wire

// File: rtl/cfg_regs.sv
`default_nettype none

module cfg_regs (
	input  logic              clk,
	input  logic              rst,
	input  cfg_pkg::apb_req_t apb_req,
	output cfg_pkg::apb_rsp_t apb_rsp,
	output cfg_pkg::sys_cfg_t sys_cfg
);
	import cfg_pkg::*;

	sys_cfg_t cfg_q;
	logic     access;
	logic     addr_ok;

	assign access  = apb_req.psel & apb_req.penable;
	assign addr_ok = (apb_req.paddr == REG_MAP_IDX) || (apb_req.paddr == REG_FLAGS);

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_q <= '0;
		end else if (access && apb_req.pwrite && addr_ok) begin
			if (apb_req.paddr == REG_MAP_IDX) begin
				cfg_q.map_idx <= apb_req.pwdata[7:0];
			end else begin
				cfg_q.mirror_v <= apb_req.pwdata[0];
				cfg_q.prg_mask <= apb_req.pwdata[12:8];  // flags layout.
			end
		end
	end

	always_comb begin
		apb_rsp.pready  = 1'b1;  // never waits.
		apb_rsp.pslverr = access & ~addr_ok;
		case (apb_req.paddr)
			REG_MAP_IDX: begin
				apb_rsp.prdata = {24'd0, cfg_q.map_idx};
			end
			REG_FLAGS: begin
				apb_rsp.prdata = {19'd0, cfg_q.prg_mask, 7'd0, cfg_q.mirror_v};
			end
			default: begin
				apb_rsp.prdata = '0;
			end
		endcase
	end

	// new config seen by the mappers the cycle after the write.
	assign sys_cfg = cfg_q;

endmodule

`default_nettype wire

// File: rtl/map_pkg.sv
`default_nettype none

package map_pkg;

	typedef struct packed {
		logic [15:0] cpu_addr;
		logic [7:0]  cpu_data;
		logic        cpu_we;    // one cycle per cpu write.
		logic [13:0] ppu_addr;
	} cpu_bus_t;

	typedef struct packed {
		logic [18:0] prg_addr;  // byte address into prg rom.
		logic [16:0] chr_addr;
		logic        ciram_a10;
		logic        chr_ce;
	} map_out_t;

	localparam logic [7:0] MAP_NOM = 8'd0;
	localparam logic [7:0] MAP_001 = 8'd1;
	localparam logic [7:0] MAP_002 = 8'd2;
	localparam logic [7:0] MAP_066 = 8'd66;

	localparam logic [15:0] ROM_BASE = 16'h8000;  // mapper registers from here up.
	localparam logic [13:0] NT_BASE  = 14'h2000;  // ppu nametables start here.

	// cpu write into the register window.
	function automatic logic rom_wr(cpu_bus_t b);
		return b.cpu_we && (b.cpu_addr >= ROM_BASE);
	endfunction

	function automatic logic chr_sel(logic [13:0] pa);
		return pa < NT_BASE;
	endfunction

	// hardwired mirroring, vertical takes a10, horizontal a11.
	function automatic logic nt_a10(logic [13:0] pa, logic mir_v);
		return mir_v ? pa[10] : pa[11];
	endfunction

endpackage

`default_nettype wire

// File: rtl/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

	// one word, set by the host before the console starts.
	typedef struct packed {
		logic [7:0] map_idx;
		logic       mirror_v;  // 1 = vertical.
		logic [4:0] prg_mask;  // 16 KB banks minus one.
	} sys_cfg_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// register byte offsets.
	localparam logic [3:0] REG_MAP_IDX = 4'h0;
	localparam logic [3:0] REG_FLAGS   = 4'h4;

endpackage

`default_nettype wire
